/* Makefile */
# Verilator build and run of the link self-test testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module link_test_tb \
		-Mdir obj_dir -f all.f
	./obj_dir/Vlink_test_tb > sim.log 2>&1; cat sim.log
	@if grep -qF '** FAIL **' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF '** PASS **' sim.log || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* all.f */
hw/link_test_pkg.sv
hw/frame_gen.sv
hw/frame_chk.sv
hw/test_regs.sv
hw/led_blink.sv
hw/link_test_top.sv
tb/link_test_props.sv
tb/link_test_tb.sv

/* hw/frame_chk.sv */
`timescale 1ns/1ps

module frame_chk (
    input  logic                             clk20_g,
    input  logic                             reset_i,
    input  logic                             run_i,
    input  logic [link_test_pkg::LEN_W-1:0]  frame_len_i,
    input  logic                             cnt_clr_i,
    input  logic [link_test_pkg::DATA_W-1:0] rx_data_i,
    input  logic                             rx_valid_i,
    input  logic                             rx_sof_i,
    input  logic                             rx_eof_i,
    input  logic                             rx_fr_good_i,
    input  logic                             rx_fr_err_i,
    output logic [link_test_pkg::CNT_W-1:0]  good_cnt_o,
    output logic [link_test_pkg::CNT_W-1:0]  bad_cnt_o,
    output logic                             err_o
);
    import link_test_pkg::*;

    logic              run_q;
    logic              run_rise;
    logic              restart_pend_q;
    logic              restart;
    logic              sof_v;
    logic              eof_v;
    logic [DATA_W-1:0] exp_num_q;
    logic [DATA_W-1:0] frame_base;
    logic [DATA_W-1:0] cur_num;
    logic [DATA_W-1:0] exp_byte;
    logic [LEN_W-1:0]  idx_q;
    logic [LEN_W-1:0]  idx_cur;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  len_cur;
    logic              len_bad;
    logic              byte_fault;
    logic              fault_q;
    logic              frame_bad;

    assign sof_v = rx_valid_i & rx_sof_i;
    assign eof_v = rx_valid_i & rx_eof_i;

    // a run restart only takes effect at the next sof, so the frame
    // still in flight keeps its old number
    assign run_rise   = run_i & ~run_q;
    assign restart    = run_rise | restart_pend_q;
    assign frame_base = restart ? '0 : exp_num_q;

    // number and index of the byte on the port this cycle
    assign cur_num  = sof_v ? frame_base : exp_num_q;
    assign idx_cur  = sof_v ? '0 : idx_q;
    assign len_cur  = sof_v ? frame_len_i : len_q;
    assign exp_byte = cur_num + DATA_W'(idx_cur);

    // eof must sit exactly on the last byte
    assign len_bad = eof_v ? (idx_cur != len_cur - 1'b1)
                           : (idx_cur >= len_cur - 1'b1);

    assign byte_fault = (rx_data_i != exp_byte) | len_bad | rx_fr_err_i |
                        (eof_v & ~rx_fr_good_i);
    assign frame_bad  = byte_fault | (fault_q & ~sof_v);

    // ------------------------------------------------------------------
    // frame tracking
    // ------------------------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            run_q          <= 1'b0;
            restart_pend_q <= 1'b0;
            exp_num_q      <= '0;
            idx_q          <= '0;
            fault_q        <= 1'b0;
        end else begin
            run_q <= run_i;
            if (run_rise) begin
                restart_pend_q <= 1'b1;
            end
            if (rx_valid_i) begin
                // index saturates so an overlong frame cannot wrap
                idx_q   <= (idx_cur == '1) ? idx_cur : idx_cur + 1'b1;
                fault_q <= frame_bad;
                if (sof_v) begin
                    restart_pend_q <= 1'b0;
                    exp_num_q      <= frame_base;
                end
                // number advances at every eof, good or bad
                if (eof_v) begin
                    exp_num_q <= cur_num + 1'b1;
                end
            end
        end
    end

    // length is taken at sof
    always_ff @(posedge clk20_g) begin
        if (sof_v) begin
            len_q <= frame_len_i;
        end
    end

    // ------------------------------------------------------------------
    // counters and sticky error
    // ------------------------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            good_cnt_o <= '0;
            bad_cnt_o  <= '0;
            err_o      <= 1'b0;
        end else if (cnt_clr_i) begin
            good_cnt_o <= '0;
            bad_cnt_o  <= '0;
            err_o      <= 1'b0;
        end else if (eof_v) begin
            if (frame_bad) begin
                err_o <= 1'b1;
                if (bad_cnt_o != '1) begin
                    bad_cnt_o <= bad_cnt_o + 1'b1;
                end
            end else if (good_cnt_o != '1) begin
                good_cnt_o <= good_cnt_o + 1'b1;
            end
        end
    end

endmodule

/* hw/frame_gen.sv */
`timescale 1ns/1ps

module frame_gen #(
    parameter int GAP_CYCLES = 12
) (
    input  logic                             clk20_g,
    input  logic                             reset_i,
    input  logic                             run_i,
    input  logic [link_test_pkg::LEN_W-1:0]  frame_len_i,
    output logic [link_test_pkg::DATA_W-1:0] tx_data_o,
    output logic                             tx_valid_o,
    output logic                             tx_sof_o,
    output logic                             tx_eof_o
);
    import link_test_pkg::*;

    localparam int GAP_W = $clog2(GAP_CYCLES + 1);

    gen_state_t        state_q;
    logic              run_q;
    logic              run_rise;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  byte_idx_q;
    logic [GAP_W-1:0]  gap_cnt_q;
    logic [DATA_W-1:0] frame_num_q;
    logic [DATA_W-1:0] num_next;
    logic [DATA_W-1:0] byte_val_q;
    logic              gap_done;
    logic              last_byte;
    logic              frame_start;

    // numbering starts over on every rising edge of run
    assign run_rise = run_i & ~run_q;
    assign num_next = run_rise ? '0 : frame_num_q;

    assign gap_done  = (gap_cnt_q == GAP_W'(GAP_CYCLES - 1));
    assign last_byte = (byte_idx_q == len_q - 1'b1);

    // a new frame may begin from idle, or right after a full gap
    assign frame_start = run_i &
                         ((state_q == GEN_IDLE) || (state_q == GEN_GAP && gap_done));

    // ------------------------------------------------------------------
    // control FSM and strobes
    // ------------------------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            state_q     <= GEN_IDLE;
            run_q       <= 1'b0;
            byte_idx_q  <= '0;
            gap_cnt_q   <= '0;
            frame_num_q <= '0;
            tx_valid_o  <= 1'b0;
            tx_sof_o    <= 1'b0;
            tx_eof_o    <= 1'b0;
        end else begin
            run_q      <= run_i;
            tx_valid_o <= 1'b0;
            tx_sof_o   <= 1'b0;
            tx_eof_o   <= 1'b0;

            if (run_rise) begin
                frame_num_q <= '0;
            end

            case (state_q)
                GEN_SEND: begin
                    tx_valid_o <= 1'b1;
                    tx_sof_o   <= (byte_idx_q == '0);
                    tx_eof_o   <= last_byte;
                    byte_idx_q <= byte_idx_q + 1'b1;
                    if (last_byte) begin
                        state_q   <= GEN_GAP;
                        gap_cnt_q <= '0;
                    end
                end
                GEN_GAP: begin
                    gap_cnt_q <= gap_cnt_q + 1'b1;
                    // stays idle unless run is still set, see frame_start
                    if (gap_done) begin
                        state_q <= GEN_IDLE;
                    end
                end
                default: begin
                end
            endcase

            if (frame_start) begin
                state_q     <= GEN_SEND;
                byte_idx_q  <= '0;
                frame_num_q <= num_next + 1'b1;
            end
        end
    end

    // byte pattern, frame number plus byte index
    always_ff @(posedge clk20_g) begin
        if (frame_start) begin
            len_q      <= frame_len_i;
            byte_val_q <= num_next;
        end else if (state_q == GEN_SEND) begin
            byte_val_q <= byte_val_q + 1'b1;
        end
        if (state_q == GEN_SEND) begin
            tx_data_o <= byte_val_q;
        end
    end

endmodule

/* hw/led_blink.sv */
`timescale 1ns/1ps

module led_blink #(
    parameter int CLK_PER_US    = 20,
    parameter int BLINK_HALF_MS = 125
) (
    input  logic clk20_g,
    input  logic reset_i,
    input  logic err_i,
    input  logic led_off_i,
    output logic led_o
);

    localparam int US_PER_MS = 1000;
    localparam int US_W      = $clog2(CLK_PER_US + 1);
    localparam int MS_W      = $clog2(US_PER_MS + 1);
    localparam int HALF_W    = $clog2(BLINK_HALF_MS + 1);

    logic [US_W-1:0]   us_cnt_q;
    logic [MS_W-1:0]   ms_cnt_q;
    logic [HALF_W-1:0] half_cnt_q;
    logic              us_tick;
    logic              ms_wrap;
    logic              ms_tick;
    logic              phase_q;

    assign us_tick = (us_cnt_q == US_W'(CLK_PER_US - 1));
    assign ms_wrap = (ms_cnt_q == MS_W'(US_PER_MS - 1));
    assign ms_tick = us_tick & ms_wrap;

    // clock -> us -> ms -> blink phase
    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            us_cnt_q   <= '0;
            ms_cnt_q   <= '0;
            half_cnt_q <= '0;
            phase_q    <= 1'b0;
        end else begin
            us_cnt_q <= us_tick ? '0 : us_cnt_q + 1'b1;
            if (us_tick) begin
                ms_cnt_q <= ms_wrap ? '0 : ms_cnt_q + 1'b1;
            end
            if (ms_tick) begin
                if (half_cnt_q == HALF_W'(BLINK_HALF_MS - 1)) begin
                    half_cnt_q <= '0;
                    phase_q    <= ~phase_q;
                end else begin
                    half_cnt_q <= half_cnt_q + 1'b1;
                end
            end
        end
    end

    // off wins, then steady on for a seen error, else blink
    assign led_o = led_off_i ? 1'b0 : (err_i | phase_q);

endmodule

/* hw/link_test_pkg.sv */
package link_test_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------

    // one frame byte on the MAC-style ports
    localparam int DATA_W = 8;

    // software register width
    localparam int REG_W = 16;

    // frame length field, frames run from 4 to 255 bytes
    localparam int LEN_W = 8;

    // good and bad frame counters, saturating
    localparam int CNT_W = 16;

    // length limits and reset value
    localparam logic [LEN_W-1:0] MIN_LEN = 8'd4;
    localparam logic [LEN_W-1:0] RST_LEN = 8'd64;

    // ------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------

    // register map
    // ctrl: bit 0 run, bit 1 led_off
    // good and bad are read-only, writing either clears both counters
    typedef enum logic [1:0] {
        REG_CTRL = 2'd0,
        REG_LEN  = 2'd1,
        REG_GOOD = 2'd2,
        REG_BAD  = 2'd3
    } reg_addr_t;

    // frame generator states
    typedef enum logic [1:0] {
        GEN_IDLE = 2'd0,
        GEN_SEND = 2'd1,
        GEN_GAP  = 2'd2
    } gen_state_t;

endpackage

/* hw/link_test_top.sv */
`timescale 1ns/1ps

module link_test_top #(
    parameter int GAP_CYCLES    = 12,
    parameter int CLK_PER_US    = 20,
    parameter int BLINK_HALF_MS = 125
) (
    input  logic                             clk20_g,
    input  logic                             reset_i,
    // register port
    input  logic                             reg_we_i,
    input  link_test_pkg::reg_addr_t         reg_addr_i,
    input  logic [link_test_pkg::REG_W-1:0]  reg_wdata_i,
    output logic [link_test_pkg::REG_W-1:0]  reg_rdata_o,
    // transmit port
    output logic [link_test_pkg::DATA_W-1:0] tx_data_o,
    output logic                             tx_valid_o,
    output logic                             tx_sof_o,
    output logic                             tx_eof_o,
    // receive port, looped back off chip
    input  logic [link_test_pkg::DATA_W-1:0] rx_data_i,
    input  logic                             rx_valid_i,
    input  logic                             rx_sof_i,
    input  logic                             rx_eof_i,
    input  logic                             rx_fr_good_i,
    input  logic                             rx_fr_err_i,
    // status
    output logic                             err_o,
    output logic                             led_o
);
    import link_test_pkg::*;

    logic             run;
    logic [LEN_W-1:0] frame_len;
    logic             led_off;
    logic             cnt_clr;
    logic [CNT_W-1:0] good_cnt;
    logic [CNT_W-1:0] bad_cnt;

    test_regs u_regs (
        .clk20_g     (clk20_g),
        .reset_i     (reset_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .good_cnt_i  (good_cnt),
        .bad_cnt_i   (bad_cnt),
        .reg_rdata_o (reg_rdata_o),
        .run_o       (run),
        .frame_len_o (frame_len),
        .led_off_o   (led_off),
        .cnt_clr_o   (cnt_clr)
    );

    frame_gen #(
        .GAP_CYCLES (GAP_CYCLES)
    ) u_gen (
        .clk20_g     (clk20_g),
        .reset_i     (reset_i),
        .run_i       (run),
        .frame_len_i (frame_len),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o),
        .tx_sof_o    (tx_sof_o),
        .tx_eof_o    (tx_eof_o)
    );

    frame_chk u_chk (
        .clk20_g      (clk20_g),
        .reset_i      (reset_i),
        .run_i        (run),
        .frame_len_i  (frame_len),
        .cnt_clr_i    (cnt_clr),
        .rx_data_i    (rx_data_i),
        .rx_valid_i   (rx_valid_i),
        .rx_sof_i     (rx_sof_i),
        .rx_eof_i     (rx_eof_i),
        .rx_fr_good_i (rx_fr_good_i),
        .rx_fr_err_i  (rx_fr_err_i),
        .good_cnt_o   (good_cnt),
        .bad_cnt_o    (bad_cnt),
        .err_o        (err_o)
    );

    // activity LED follows the sticky checker error
    led_blink #(
        .CLK_PER_US    (CLK_PER_US),
        .BLINK_HALF_MS (BLINK_HALF_MS)
    ) u_led (
        .clk20_g   (clk20_g),
        .reset_i   (reset_i),
        .err_i     (err_o),
        .led_off_i (led_off),
        .led_o     (led_o)
    );

endmodule

/* hw/test_regs.sv */
`timescale 1ns/1ps

module test_regs (
    input  logic                             clk20_g,
    input  logic                             reset_i,
    input  logic                             reg_we_i,
    input  link_test_pkg::reg_addr_t         reg_addr_i,
    input  logic [link_test_pkg::REG_W-1:0]  reg_wdata_i,
    input  logic [link_test_pkg::CNT_W-1:0]  good_cnt_i,
    input  logic [link_test_pkg::CNT_W-1:0]  bad_cnt_i,
    output logic [link_test_pkg::REG_W-1:0]  reg_rdata_o,
    output logic                             run_o,
    output logic [link_test_pkg::LEN_W-1:0]  frame_len_o,
    output logic                             led_off_o,
    output logic                             cnt_clr_o
);
    import link_test_pkg::*;

    logic [LEN_W-1:0] len_clamped;

    // written lengths are pulled into the 4 to 255 range
    assign len_clamped = (|reg_wdata_i[REG_W-1:LEN_W])         ? '1      :
                         (reg_wdata_i[LEN_W-1:0] < MIN_LEN)    ? MIN_LEN :
                                                                 reg_wdata_i[LEN_W-1:0];

    // clear acts at the write edge itself
    assign cnt_clr_o = reg_we_i & ((reg_addr_i == REG_GOOD) || (reg_addr_i == REG_BAD));

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (reset_i) begin
            run_o       <= 1'b0;
            led_off_o   <= 1'b0;
            frame_len_o <= RST_LEN;
        end else if (reg_we_i) begin
            case (reg_addr_i)
                REG_CTRL: begin
                    run_o     <= reg_wdata_i[0];
                    led_off_o <= reg_wdata_i[1];
                end
                REG_LEN: begin
                    frame_len_o <= len_clamped;
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // read side, one cycle after the address
    // ------------------------------------------------------------------
    always_ff @(posedge clk20_g) begin
        case (reg_addr_i)
            REG_CTRL: reg_rdata_o <= REG_W'({led_off_o, run_o});
            REG_LEN:  reg_rdata_o <= REG_W'(frame_len_o);
            REG_GOOD: reg_rdata_o <= REG_W'(good_cnt_i);
            default:  reg_rdata_o <= REG_W'(bad_cnt_i);
        endcase
    end

endmodule

/* tb/link_test_props.sv */
`timescale 1ns/1ps

module link_test_props (
    input logic clk20_g,
    input logic reset_i,
    input logic tx_valid_i,
    input logic tx_sof_i,
    input logic tx_eof_i
);

    // framing strobes only ride on valid
    strobes_need_valid: assert property (
        @(posedge clk20_g) disable iff (reset_i)
        (tx_sof_i | tx_eof_i) |-> tx_valid_i
    ) else $error("tx sof or eof without valid");

    // no hole between sof and eof
    valid_until_eof: assert property (
        @(posedge clk20_g) disable iff (reset_i)
        (tx_valid_i && !tx_eof_i) |=> tx_valid_i
    ) else $error("tx valid dropped inside a frame");

    // a frame can only open with sof
    valid_opens_with_sof: assert property (
        @(posedge clk20_g) disable iff (reset_i)
        $rose(tx_valid_i) |-> tx_sof_i
    ) else $error("tx valid rose without sof");

    quiet_in_reset: assert property (
        @(posedge clk20_g)
        reset_i |=> (!tx_valid_i && !tx_sof_i && !tx_eof_i)
    ) else $error("tx strobes active during reset");

endmodule

bind frame_gen link_test_props u_props (
    .clk20_g    (clk20_g),
    .reset_i    (reset_i),
    .tx_valid_i (tx_valid_o),
    .tx_sof_i   (tx_sof_o),
    .tx_eof_i   (tx_eof_o)
);

/* tb/link_test_tb.sv */
`timescale 1ns/1ps

module link_test_tb;
    import link_test_pkg::*;

    localparam int GAP_CYCLES    = 12;
    localparam int CLK_PER_US    = 2;
    localparam int BLINK_HALF_MS = 1;
    localparam int LED_HALF      = CLK_PER_US * 1000 * BLINK_HALF_MS;
    localparam int N_CLEAN       = 12;
    localparam int N_FAULT       = 40;
    localparam int N_SHORT       = 6;
    localparam int FRAME_MAX     = 256 + GAP_CYCLES;
    // every run at the longest length, plus the LED phases and a margin
    localparam int WD_CYCLES     = (N_CLEAN + N_FAULT + N_SHORT + 8) * FRAME_MAX
                                   + 12 * LED_HALF + 2000;

    logic              clk20_g;
    logic              reset_i;
    logic              reg_we;
    reg_addr_t         reg_addr;
    logic [REG_W-1:0]  reg_wdata;
    logic [REG_W-1:0]  reg_rdata;
    logic [DATA_W-1:0] tx_data;
    logic              tx_valid;
    logic              tx_sof;
    logic              tx_eof;
    logic [DATA_W-1:0] rx_data;
    logic              rx_valid;
    logic              rx_sof;
    logic              rx_eof;
    logic              rx_fr_good;
    logic              rx_fr_err;
    logic              err;
    logic              led;

    // reference model state
    integer            seed;
    int                n_mismatch;
    int                n_other;
    logic [LEN_W-1:0]  model_len;
    logic [LEN_W-1:0]  k;
    logic [DATA_W-1:0] tx_num;
    logic              in_frame;
    int                frames_sent;
    int                sof_seen;
    logic [CNT_W-1:0]  exp_good;
    logic [CNT_W-1:0]  exp_bad;
    logic              fault_en;
    int                fault_kind;
    logic [LEN_W-1:0]  fault_pos;
    logic              led_off_bit;

    link_test_top #(
        .GAP_CYCLES    (GAP_CYCLES),
        .CLK_PER_US    (CLK_PER_US),
        .BLINK_HALF_MS (BLINK_HALF_MS)
    ) DUT (
        .clk20_g      (clk20_g),
        .reset_i      (reset_i),
        .reg_we_i     (reg_we),
        .reg_addr_i   (reg_addr),
        .reg_wdata_i  (reg_wdata),
        .reg_rdata_o  (reg_rdata),
        .tx_data_o    (tx_data),
        .tx_valid_o   (tx_valid),
        .tx_sof_o     (tx_sof),
        .tx_eof_o     (tx_eof),
        .rx_data_i    (rx_data),
        .rx_valid_i   (rx_valid),
        .rx_sof_i     (rx_sof),
        .rx_eof_i     (rx_eof),
        .rx_fr_good_i (rx_fr_good),
        .rx_fr_err_i  (rx_fr_err),
        .err_o        (err),
        .led_o        (led)
    );

    initial begin
        clk20_g = 1'b0;
        forever #5 clk20_g = ~clk20_g;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk20_g);
        $display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------------------------------------------
    // compare tasks and helpers
    // ------------------------------------------------------------------
    task automatic check_byte(input string name, input logic [DATA_W-1:0] exp_v,
                              input logic [DATA_W-1:0] act_v);
        if (act_v !== exp_v) begin
            n_mismatch++;
            $display("mismatch %s: expected %02h, actual %02h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task automatic check_cnt(input string name, input logic [CNT_W-1:0] exp_v,
                             input logic [CNT_W-1:0] act_v);
        if (act_v !== exp_v) begin
            n_mismatch++;
            $display("mismatch %s: expected %0d, actual %0d at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            n_mismatch++;
            $display("mismatch %s: expected %b, actual %b at %0t", name, exp_v, act_v, $time);
        end
    endtask

    function automatic int pick_random(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // lengths below 4 are pulled up to 4
    function automatic logic [LEN_W-1:0] clamp_len(input logic [REG_W-1:0] w);
        if (w < REG_W'(4)) begin
            return LEN_W'(4);
        end
        return w[LEN_W-1:0];
    endfunction

    function automatic logic [REG_W-1:0] ctrl_word(input logic run);
        return REG_W'({led_off_bit, run});
    endfunction

    task automatic write_reg(input reg_addr_t addr, input logic [REG_W-1:0] data);
        @(negedge clk20_g);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk20_g);
        reg_we    = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output logic [REG_W-1:0] data);
        @(negedge clk20_g);
        reg_addr = addr;
        @(negedge clk20_g);
        data = reg_rdata;
    endtask

    task automatic check_counts(input string name);
        logic [REG_W-1:0] rd;
        read_reg(REG_GOOD, rd);
        check_cnt({name, " good"}, exp_good, CNT_W'(rd));
        read_reg(REG_BAD, rd);
        check_cnt({name, " bad"}, exp_bad, CNT_W'(rd));
    endtask

    task automatic start_run(input logic [REG_W-1:0] len_w);
        write_reg(REG_LEN, len_w);
        model_len = clamp_len(len_w);
        tx_num    = '0;
        write_reg(REG_CTRL, ctrl_word(1'b1));
    endtask

    // current frame finishes, then loopback and counters settle
    task automatic stop_run();
        int t;
        write_reg(REG_CTRL, ctrl_word(1'b0));
        repeat (2) @(posedge clk20_g);
        t = 0;
        while (in_frame && t < FRAME_MAX) begin
            @(posedge clk20_g);
            t++;
        end
        if (in_frame) begin
            n_other++;
            $display("frame still running %0d cycles after run was cleared", t);
        end
        repeat (4) @(posedge clk20_g);
    endtask

    task automatic run_frames(input int n, input logic [REG_W-1:0] len_w);
        int target;
        int t;
        target = frames_sent + n;
        start_run(len_w);
        t = 0;
        while (frames_sent < target && t < n * FRAME_MAX + 16) begin
            @(posedge clk20_g);
            t++;
        end
        if (frames_sent < target) begin
            n_other++;
            $display("generator stalled, %0d of %0d frames sent", frames_sent, target);
        end
        stop_run();
    endtask

    task automatic measure_led(output int cycles);
        logic start;
        start  = led;
        cycles = 0;
        while (led === start && cycles < 2 * LED_HALF + 8) begin
            @(negedge clk20_g);
            cycles++;
        end
        if (led === start) begin
            n_other++;
            $display("led_o did not toggle within %0d cycles", cycles);
        end
    endtask

    task automatic hold_led(input string name, input logic exp_v, input int n);
        int bad;
        bad = 0;
        repeat (n) begin
            @(negedge clk20_g);
            if (led !== exp_v) begin
                bad++;
            end
        end
        if (bad != 0) begin
            n_other++;
            $display("%s: led_o left level %b on %0d of %0d cycles", name, exp_v, bad, n);
        end
    endtask

    // ------------------------------------------------------------------
    // loopback with fault injection and transmit pattern checks
    // ------------------------------------------------------------------
    always @(negedge clk20_g) begin : loopback
        logic [DATA_W-1:0] data_v;
        logic              good_v;
        logic              ferr_v;
        data_v = '0;
        good_v = 1'b1;
        ferr_v = 1'b0;
        if (!reset_i && tx_valid) begin
            data_v = tx_data;
            if (tx_sof) begin
                sof_seen++;
                // kinds 1 to 3 are faults, so about half the frames
                fault_kind = fault_en ? pick_random(6) : 0;
                fault_pos  = LEN_W'(pick_random(int'(model_len)));
            end
            check_bit("tx sof", (k == '0), tx_sof);
            check_bit("tx eof", (k == model_len - 1'b1), tx_eof);
            check_byte("tx data", tx_num + DATA_W'(k), tx_data);
            if (k == fault_pos && fault_kind == 1) begin
                data_v = tx_data ^ (DATA_W'(1) << pick_random(DATA_W));
            end
            if (k == fault_pos && fault_kind == 3) begin
                ferr_v = 1'b1;
            end
            if (tx_eof) begin
                if (fault_kind == 2) begin
                    good_v = 1'b0;
                end
                if (fault_kind >= 1 && fault_kind <= 3) begin
                    exp_bad++;
                end else begin
                    exp_good++;
                end
                frames_sent++;
                tx_num++;
                k        = '0;
                in_frame = 1'b0;
            end else begin
                k++;
                in_frame = 1'b1;
            end
        end
        rx_data    = data_v;
        rx_valid   = tx_valid & ~reset_i;
        rx_sof     = tx_sof & ~reset_i;
        rx_eof     = tx_eof & ~reset_i;
        rx_fr_good = good_v;
        rx_fr_err  = ferr_v;
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin : main
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] wlen;
        int               len;
        int               sent;
        int               sofs;
        int               half;
        int               t;
        seed        = 52;
        n_mismatch  = 0;
        n_other     = 0;
        reset_i     = 1'b1;
        reg_we      = 1'b0;
        reg_addr    = REG_CTRL;
        reg_wdata   = '0;
        rx_data     = '0;
        rx_valid    = 1'b0;
        rx_sof      = 1'b0;
        rx_eof      = 1'b0;
        rx_fr_good  = 1'b0;
        rx_fr_err   = 1'b0;
        model_len   = LEN_W'(64);
        k           = '0;
        tx_num      = '0;
        in_frame    = 1'b0;
        frames_sent = 0;
        sof_seen    = 0;
        exp_good    = '0;
        exp_bad     = '0;
        fault_en    = 1'b0;
        fault_kind  = 0;
        fault_pos   = '0;
        led_off_bit = 1'b0;
        repeat (16) @(posedge clk20_g);
        @(negedge clk20_g);
        reset_i = 1'b0;

        // reset values
        read_reg(REG_CTRL, rd);
        check_cnt("ctrl after reset", '0, CNT_W'(rd));
        read_reg(REG_LEN, rd);
        check_cnt("len after reset", CNT_W'(64), CNT_W'(rd));
        check_counts("after reset");
        check_bit("err after reset", 1'b0, err);
        check_bit("led after reset", 1'b0, led);
        t = 0;
        repeat (20) begin
            @(negedge clk20_g);
            if (tx_valid !== 1'b0) begin
                t++;
            end
        end
        check_cnt("tx valid cycles while idle", '0, CNT_W'(t));

        // clean loopback
        run_frames(N_CLEAN, REG_W'(8 + pick_random(64)));
        check_cnt("clean frames sent", CNT_W'(N_CLEAN), CNT_W'(frames_sent));
        check_counts("clean run");
        check_bit("err after clean run", 1'b0, err);

        // random faults make err sticky and the LED steady on
        fault_en = 1'b1;
        run_frames(N_FAULT, REG_W'(8 + pick_random(64)));
        fault_en = 1'b0;
        check_counts("fault run");
        check_bit("err after faults", (exp_bad != '0), err);
        hold_led("led with err set", 1'b1, LED_HALF + 20);

        // stop in mid-frame, then clear both counters
        len  = 8 + pick_random(64);
        sofs = sof_seen;
        start_run(REG_W'(len));
        @(negedge clk20_g);
        check_bit("sof one cycle after run", 1'b0, tx_sof);
        @(negedge clk20_g);
        check_bit("sof two cycles after run", 1'b1, tx_sof);
        repeat (2) @(posedge clk20_g);
        sent = frames_sent;
        stop_run();
        check_cnt("frames finished after stop", CNT_W'(sent + 1), CNT_W'(frames_sent));
        repeat (2 * (len + GAP_CYCLES)) @(posedge clk20_g);
        check_cnt("sof count after stop", CNT_W'(sofs + 1), CNT_W'(sof_seen));
        check_counts("stopped run");
        write_reg(REG_GOOD, '0);
        exp_good = '0;
        exp_bad  = '0;
        check_counts("after clear");
        check_bit("err after clear", 1'b0, err);

        // short lengths clamp to 4
        wlen = REG_W'(pick_random(4));
        write_reg(REG_LEN, wlen);
        read_reg(REG_LEN, rd);
        check_cnt("short length readback", CNT_W'(clamp_len(wlen)), CNT_W'(rd));
        run_frames(N_SHORT, wlen);
        check_counts("short frames");

        // blink period with err clear, then forced off
        measure_led(half);
        measure_led(half);
        check_cnt("led half period", CNT_W'(LED_HALF), CNT_W'(half));
        measure_led(half);
        check_cnt("led next half period", CNT_W'(LED_HALF), CNT_W'(half));
        led_off_bit = 1'b1;
        write_reg(REG_CTRL, ctrl_word(1'b0));
        hold_led("led with led_off set", 1'b0, 2 * LED_HALF + 20);

        $display("checks done with %0d mismatches and %0d other errors", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
